//--- dv/bus_checker.sv
/*
  bus_checker: reference model of RAM, LEDs and serial loopback;
  compares every completed bus read, transfer lengths and the LED outputs
*/

`timescale 1ns/1ps

module bus_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [soc_map_pkg::ADR_W-1:0]  adr,
  input  logic                           rd,
  input  logic                           wr,
  input  logic                           ben,
  input  logic [soc_map_pkg::DATA_W-1:0] outbus,
  input  logic [soc_map_pkg::DATA_W-1:0] inbus,
  input  logic                           memwait,
  input  logic [io_pkg::LED_W-1:0]       led_g,
  input  logic [io_pkg::SW_W-1:0]        sw,
  output int                             n_checks,
  output int                             n_errors
);

  logic [soc_map_pkg::DATA_W-1:0] mem_model [soc_map_pkg::RAM_WORDS];
  logic [io_pkg::LED_W-1:0]       led_model;
  logic [7:0]                     tx_q [$];
  int                             checks;
  int                             errs;
  int                             xfer_len;

  initial begin
    for (int i = 0; i < soc_map_pkg::RAM_WORDS; i++) begin
      mem_model[i] = '0;
    end
    checks   = 0;
    errs     = 0;
    xfer_len = 0;
  end

  // higher RAM address bits alias onto adr[11:2]
  function automatic logic [31:0] ram_expect(input logic [23:0] a, input logic b);
    logic [31:0] w;
    w = mem_model[a[soc_map_pkg::RAM_AW-1:2]];
    if (b) begin
      return {24'h0, w[{a[1:0], 3'b000} +: 8]};
    end
    return w;
  endfunction

  // transfer length in cycles
  function automatic int xfer_cycles(input logic [23:0] a, input logic r);
    return (r && (a[23:20] == soc_map_pkg::RAM_REGION)) ? 2 : 1;
  endfunction

  // ------------------------------------------------------------
  // read comparison
  // ------------------------------------------------------------

  task automatic check_read();
    logic [31:0] exp;
    logic        known;
    known = 1'b1;
    exp   = '0;
    if (adr[23:20] == soc_map_pkg::RAM_REGION) begin
      exp = ram_expect(adr, ben);
    end else if (adr[23:6] == soc_map_pkg::IO_PREFIX) begin
      case (adr[5:2])
        // timer and serial status are timing dependent
        soc_map_pkg::DEV_TMR:      known = 1'b0;
        soc_map_pkg::DEV_SER_STAT: known = 1'b0;
        soc_map_pkg::DEV_BIO:      exp = {14'h0, sw};
        soc_map_pkg::DEV_SER_DATA: begin
          if (tx_q.size() == 0) begin
            $display("serial data read at %0t with no byte sent", $time);
            errs++;
            known = 1'b0;
          end else begin
            exp = {24'h0, tx_q.pop_front()};
          end
        end
        default:                   exp = '0;
      endcase
    end else begin
      known = 1'b0;
    end
    if (known) begin
      checks++;
      if (inbus !== exp) begin
        $display("ERR %0t: read adr %06h ben %0b got %08h exp %08h",
                 $time, adr, ben, inbus, exp);
        errs++;
      end
    end
  endtask

  task automatic check_latency();
    int exp_len;
    exp_len = xfer_cycles(adr, rd);
    xfer_len++;
    if (!memwait) begin
      if (xfer_len != exp_len) begin
        $display("ERR %0t: transfer at adr %06h took %0d cycles exp %0d",
                 $time, adr, xfer_len, exp_len);
        errs++;
      end
      xfer_len = 0;
    end else if (xfer_len >= exp_len) begin
      $display("ERR %0t: memwait still high after %0d cycles at adr %06h",
               $time, xfer_len, adr);
      errs++;
    end
  endtask

  task automatic apply_write();
    if (adr[23:20] == soc_map_pkg::RAM_REGION) begin
      if (ben) begin
        mem_model[adr[soc_map_pkg::RAM_AW-1:2]][{adr[1:0], 3'b000} +: 8] = outbus[7:0];
      end else begin
        mem_model[adr[soc_map_pkg::RAM_AW-1:2]] = outbus;
      end
    end else if (adr[23:6] == soc_map_pkg::IO_PREFIX) begin
      if (adr[5:2] == soc_map_pkg::DEV_BIO) begin
        led_model = outbus[io_pkg::LED_W-1:0];
      end else if (adr[5:2] == soc_map_pkg::DEV_SER_DATA) begin
        tx_q.push_back(outbus[7:0]);
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      led_model = '0;
      xfer_len  = 0;
    end else begin
      // LEDs follow the last write from the next cycle on
      if (led_g !== led_model) begin
        $display("ERR %0t: led_g %03h exp %03h", $time, led_g, led_model);
        errs++;
      end
      if (rd || wr) begin
        check_latency();
      end else if (memwait !== 1'b0) begin
        $display("ERR %0t: memwait %0b with no transfer", $time, memwait);
        errs++;
      end
      if (rd && !memwait) begin
        check_read();
      end
      if (wr) begin
        apply_write();
      end
    end
    n_checks <= checks;
    n_errors <= errs;
  end

endmodule

//--- dv/tb_risc5_io.sv
/*
  tb_risc5_io: testbench acting as bus master for the memory and I/O
  subsystem, with serial loopback, watchdog and per-test reporting
*/

`timescale 1ns/1ps

module tb_risc5_io;

  localparam int CLK_PERIOD = 8;
  localparam int RAM_OPS    = 200;
  localparam int BYTE_OPS   = 100;
  localparam int ALIAS_OPS  = 16;
  localparam int SW_OPS     = 20;
  localparam int LED_OPS    = 20;
  localparam int SER_BYTES  = 16;
  localparam int TMR_MAX_N  = 800;
  // rough cycle budget of all tests
  localparam int EST_CYCLES = 10 + RAM_OPS * 3 + BYTE_OPS * 5 + 24 + ALIAS_OPS * 5 +
                              SW_OPS * 5 + LED_OPS * 3 +
                              SER_BYTES * 10 * io_pkg::BAUD_DIV + TMR_MAX_N + 8;

  logic                           clk;
  logic                           rst;
  logic [soc_map_pkg::ADR_W-1:0]  adr;
  logic                           rd;
  logic                           wr;
  logic                           ben;
  logic [soc_map_pkg::DATA_W-1:0] outbus;
  logic [soc_map_pkg::DATA_W-1:0] inbus;
  logic                           memwait;
  logic                           txd;
  logic [io_pkg::LED_W-1:0]       led_g;
  logic [io_pkg::SW_W-1:0]        sw;
  int                             n_checks;
  int                             chk_errors;
  int                             tb_errors;
  int                             n_pass;
  int                             n_fail;

  // txd loops back to rxd
  risc5_io DUT (
    .clk(clk), .rst(rst), .adr(adr), .rd(rd), .wr(wr), .ben(ben),
    .outbus(outbus), .inbus(inbus), .memwait(memwait),
    .rxd(txd), .txd(txd), .led_g(led_g), .sw(sw)
  );

  bus_checker u_checker (
    .clk(clk), .rst(rst), .adr(adr), .rd(rd), .wr(wr), .ben(ben),
    .outbus(outbus), .inbus(inbus), .memwait(memwait), .led_g(led_g), .sw(sw),
    .n_checks(n_checks), .n_errors(chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(2 * EST_CYCLES * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", 2 * EST_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [23:0] io_adr(input logic [3:0] idx);
    return {soc_map_pkg::IO_PREFIX, idx, 2'b00};
  endfunction

  function automatic logic [23:0] ram_adr(input int unsigned w, input logic [7:0] hi,
                                          input logic [1:0] lane);
    return {soc_map_pkg::RAM_REGION, hi, w[soc_map_pkg::RAM_AW-3:0], lane};
  endfunction

  // ------------------------------------------------------------
  // bus master, called right after a rising edge
  // ------------------------------------------------------------

  task automatic bus_write(input logic [23:0] a, input logic [31:0] d, input logic b);
    adr    <= a;
    outbus <= d;
    ben    <= b;
    wr     <= 1'b1;
    do begin
      @(posedge clk);
    end while (memwait);
    wr <= 1'b0;
  endtask

  task automatic bus_read(input logic [23:0] a, input logic b, output logic [31:0] d);
    adr <= a;
    ben <= b;
    rd  <= 1'b1;
    do begin
      @(posedge clk);
    end while (memwait);
    d = inbus;
    rd <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    // one more edge so the checker counts are settled
    @(posedge clk);
    errs = chk_errors + tb_errors - errs_before;
    if (errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %-12s %s, %0d errors", name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] t0;
    logic [31:0] t1;
    int unsigned rnd;
    int unsigned w;
    int          errs0;
    int          n_cyc;
    int          diff;
    rnd       = $urandom(97192);
    tb_errors = 0;
    n_pass    = 0;
    n_fail    = 0;
    rst       = 1'b1;
    adr       = '0;
    rd        = 1'b0;
    wr        = 1'b0;
    ben       = 1'b0;
    outbus    = '0;
    sw        = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // full words across RAM, reads include never-written words
    errs0 = chk_errors + tb_errors;
    for (int i = 0; i < RAM_OPS; i++) begin
      bus_write(ram_adr($urandom, 8'h00, 2'b00), $urandom, 1'b0);
    end
    for (int i = 0; i < RAM_OPS; i++) begin
      bus_read(ram_adr($urandom, 8'h00, 2'b00), 1'b0, rdata);
    end
    report_test("ram_words", errs0);

    // byte lanes within a small window of words
    errs0 = chk_errors + tb_errors;
    for (int i = 0; i < BYTE_OPS; i++) begin
      w   = $urandom_range(0, 63);
      rnd = $urandom;
      bus_write(ram_adr(w, 8'h00, rnd[1:0]), $urandom, 1'b1);
      bus_read(ram_adr(w, 8'h00, 2'b00), 1'b0, rdata);
      bus_read(ram_adr(w, 8'h00, rnd[1:0]), 1'b1, rdata);
    end
    report_test("ram_bytes", errs0);

    // unused I/O indices and RAM aliasing
    errs0 = chk_errors + tb_errors;
    for (int idx = 4; idx < 16; idx++) begin
      bus_read(io_adr(4'(idx)), 1'b0, rdata);
    end
    for (int i = 0; i < ALIAS_OPS; i++) begin
      w = $urandom;
      bus_write(ram_adr(w, 8'($urandom_range(1, 255)), 2'b00), $urandom, 1'b0);
      bus_read(ram_adr(w, 8'h00, 2'b00), 1'b0, rdata);
      bus_read(ram_adr(w, 8'($urandom_range(1, 255)), 2'b00), 1'b0, rdata);
    end
    report_test("map", errs0);

    // switches through the synchronizer, then LEDs
    errs0 = chk_errors + tb_errors;
    for (int i = 0; i < SW_OPS; i++) begin
      rnd = $urandom;
      sw <= rnd[io_pkg::SW_W-1:0];
      repeat (3) @(posedge clk);
      bus_read(io_adr(soc_map_pkg::DEV_BIO), 1'b0, rdata);
    end
    for (int i = 0; i < LED_OPS; i++) begin
      bus_write(io_adr(soc_map_pkg::DEV_BIO), $urandom, 1'b0);
      @(posedge clk);
    end
    report_test("board_io", errs0);

    // serial loopback, one byte in flight at a time
    errs0 = chk_errors + tb_errors;
    for (int i = 0; i < SER_BYTES; i++) begin
      do begin
        bus_read(io_adr(soc_map_pkg::DEV_SER_STAT), 1'b0, rdata);
      end while (!rdata[io_pkg::SER_TX_RDY]);
      bus_write(io_adr(soc_map_pkg::DEV_SER_DATA), $urandom, 1'b0);
      do begin
        bus_read(io_adr(soc_map_pkg::DEV_SER_STAT), 1'b0, rdata);
      end while (!rdata[io_pkg::SER_RX_RDY]);
      bus_read(io_adr(soc_map_pkg::DEV_SER_DATA), 1'b0, rdata);
      bus_read(io_adr(soc_map_pkg::DEV_SER_STAT), 1'b0, rdata);
      if (rdata[io_pkg::SER_RX_RDY]) begin
        $display("ERR %0t: ser status %08h still shows rx ready after data read",
                 $time, rdata);
        tb_errors++;
      end
    end
    report_test("serial", errs0);

    // timer advance over a counted gap
    errs0 = chk_errors + tb_errors;
    bus_read(io_adr(soc_map_pkg::DEV_TMR), 1'b0, t0);
    n_cyc = $urandom_range(300, TMR_MAX_N);
    repeat (n_cyc) @(posedge clk);
    bus_read(io_adr(soc_map_pkg::DEV_TMR), 1'b0, t1);
    diff = int'(t1 - t0);
    if ((diff < n_cyc / io_pkg::TMR_DIV - 1) || (diff > n_cyc / io_pkg::TMR_DIV + 1)) begin
      $display("ERR %0t: timer advanced %0d over %0d cycles, exp %0d +/- 1",
               $time, diff, n_cyc, n_cyc / io_pkg::TMR_DIV);
      tb_errors++;
    end
    report_test("timer", errs0);

    $display("tests passed %0d, failed %0d, read checks %0d, errors %0d",
             n_pass, n_fail, n_checks, chk_errors + tb_errors);
    if ((n_fail == 0) && (chk_errors + tb_errors == 0) && (n_checks > 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- risc5_io.f
verilog/soc_map_pkg.sv
verilog/io_pkg.sv
verilog/io_bus_if.sv
verilog/bus_decode.sv
verilog/ram.sv
verilog/tmr.sv
verilog/ser.sv
verilog/bio.sv
verilog/risc5_io.sv
dv/bus_checker.sv
dv/tb_risc5_io.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run; exit status follows the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal -f risc5_io.f --top-module tb_risc5_io -o sim_tb_risc5_io &&
./obj_dir/sim_tb_risc5_io | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run_sim: pass" ||
{ echo "run_sim: fail"; exit 1; }

//--- verilog/bio.sv
/*
  bio: board I/O, green LED register and synchronized slide switches
*/

`timescale 1ns/1ps

module bio (
  input  logic                    clk,
  input  logic                    rst,
  io_bus_if.dev                   bus,
  output logic [io_pkg::LED_W-1:0] led_g,
  input  logic [io_pkg::SW_W-1:0]  sw
);

  logic [io_pkg::SW_W-1:0] sw_meta;
  logic [io_pkg::SW_W-1:0] sw_q;

  // two-stage synchronizer for the asynchronous switches
  always_ff @(posedge clk) begin
    sw_meta <= sw;
    sw_q    <= sw_meta;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      led_g <= '0;
    end else if (bus.en && bus.wr) begin
      led_g <= bus.din[io_pkg::LED_W-1:0];
    end
  end

  // switches zero-extended to the bus width
  always_comb begin
    bus.dout = '0;
    bus.dout[io_pkg::SW_W-1:0] = sw_q;
  end

endmodule

//--- verilog/bus_decode.sv
/*
  bus_decode: splits the address space into RAM and the I/O block,
  drives the device enables and multiplexes read data back to the master
*/

`timescale 1ns/1ps

module bus_decode (
  input  logic [soc_map_pkg::ADR_W-1:0]  adr,
  input  logic                           rd,
  input  logic                           wr,
  input  logic [soc_map_pkg::DATA_W-1:0] outbus,
  output logic [soc_map_pkg::DATA_W-1:0] inbus,
  output logic                           ram_en,
  input  logic [soc_map_pkg::DATA_W-1:0] ram_dout,
  io_bus_if.dec                          tmr_bus,
  io_bus_if.dec                          bio_bus,
  io_bus_if.dec                          ser_bus
);

  logic       io_en;
  logic [3:0] io_idx;

  // ------------------------------------------------------------
  // address decoder
  // ------------------------------------------------------------

  assign ram_en = (adr[soc_map_pkg::ADR_W-1:soc_map_pkg::ADR_W-4] == soc_map_pkg::RAM_REGION);
  assign io_en  = (adr[soc_map_pkg::ADR_W-1:6] == soc_map_pkg::IO_PREFIX);
  assign io_idx = adr[5:2];

  assign tmr_bus.en  = io_en & (io_idx == soc_map_pkg::DEV_TMR);
  assign tmr_bus.sel = 1'b0;
  assign tmr_bus.rd  = rd;
  assign tmr_bus.wr  = wr;
  assign tmr_bus.din = outbus;

  assign bio_bus.en  = io_en & (io_idx == soc_map_pkg::DEV_BIO);
  assign bio_bus.sel = 1'b0;
  assign bio_bus.rd  = rd;
  assign bio_bus.wr  = wr;
  assign bio_bus.din = outbus;

  // data and status share one device, sel picks status
  assign ser_bus.en  = io_en & ((io_idx == soc_map_pkg::DEV_SER_DATA) |
                                (io_idx == soc_map_pkg::DEV_SER_STAT));
  assign ser_bus.sel = (io_idx == soc_map_pkg::DEV_SER_STAT);
  assign ser_bus.rd  = rd;
  assign ser_bus.wr  = wr;
  assign ser_bus.din = outbus;

  // ------------------------------------------------------------
  // read data multiplexer
  // ------------------------------------------------------------

  // RAM unless I/O is addressed, then devices by index, else zero
  assign inbus = ~io_en      ? ram_dout     :
                 tmr_bus.en  ? tmr_bus.dout :
                 bio_bus.en  ? bio_bus.dout :
                 ser_bus.en  ? ser_bus.dout :
                 '0;

endmodule

//--- verilog/io_bus_if.sv
/*
  io_bus_if: register bus between the address decoder and one peripheral
*/

`timescale 1ns/1ps

interface io_bus_if;

  // device selected by the decoder
  logic en;
  // register select inside the device
  logic sel;
  logic rd;
  logic wr;
  logic [soc_map_pkg::DATA_W-1:0] din;
  logic [soc_map_pkg::DATA_W-1:0] dout;

  modport dec (
    output en, sel, rd, wr, din,
    input  dout
  );

  modport dev (
    input  en, sel, rd, wr, din,
    output dout
  );

endinterface

//--- verilog/io_pkg.sv
/*
  io_pkg: peripheral timing, serial framing and status bit layout
*/

package io_pkg;

  // timer prescaler, short for simulation
  localparam int TMR_DIV = 50;
  localparam int TMR_CW  = $clog2(TMR_DIV);
  localparam logic [TMR_CW-1:0] TMR_LAST = TMR_CW'(TMR_DIV - 1);

  // serial bit timing
  localparam int BAUD_DIV = 16;
  localparam int BAUD_CW  = $clog2(BAUD_DIV);
  localparam logic [BAUD_CW-1:0] BAUD_LAST = BAUD_CW'(BAUD_DIV - 1);
  localparam logic [BAUD_CW-1:0] BAUD_MID  = BAUD_CW'(BAUD_DIV / 2 - 1);

  // 8N1 framing: start, eight data bits, stop
  localparam int SER_DATA_BITS  = 8;
  localparam int SER_FRAME_BITS = SER_DATA_BITS + 2;
  localparam int SER_CNT_W      = $clog2(SER_FRAME_BITS);
  localparam logic [SER_CNT_W-1:0] SER_LAST_BIT = SER_CNT_W'(SER_FRAME_BITS - 1);

  // serial status word
  localparam int SER_RX_RDY = 0;
  localparam int SER_TX_RDY = 1;

  // board I/O widths
  localparam int LED_W = 9;
  localparam int SW_W  = 18;

endpackage

//--- verilog/ram.sv
/*
  ram: word-organized block RAM with byte lanes; reads stall the master
  for one cycle through memwait
*/

`timescale 1ns/1ps

module ram (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en,
  input  logic                           rd,
  input  logic                           wr,
  input  logic                           ben,
  input  logic [soc_map_pkg::RAM_AW-1:0] adr,
  input  logic [soc_map_pkg::DATA_W-1:0] din,
  output logic [soc_map_pkg::DATA_W-1:0] dout,
  output logic                           memwait
);

  logic [soc_map_pkg::DATA_W-1:0] mem [soc_map_pkg::RAM_WORDS];
  logic [soc_map_pkg::RAM_AW-3:0] widx;
  logic [1:0]                     lane;
  logic                           pend;

  assign widx = adr[soc_map_pkg::RAM_AW-1:2];
  assign lane = adr[1:0];

  // contents start cleared
  initial begin
    for (int i = 0; i < soc_map_pkg::RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // byte writes take the low byte of din into the addressed lane
  always_ff @(posedge clk) begin
    if (en && wr) begin
      if (ben) begin
        mem[widx][{lane, 3'b000} +: 8] <= din[7:0];
      end else begin
        mem[widx] <= din;
      end
    end
  end

  // read word or zero-extended byte, presented in the second cycle
  always_ff @(posedge clk) begin
    if (en && rd) begin
      if (ben) begin
        dout <= soc_map_pkg::DATA_W'(mem[widx][{lane, 3'b000} +: 8]);
      end else begin
        dout <= mem[widx];
      end
    end
  end

  // stall only the first cycle of a read
  assign memwait = en & rd & ~pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= 1'b0;
    end else begin
      pend <= memwait;
    end
  end

endmodule

//--- verilog/risc5_io.sv
/*
  risc5_io: RISC5 memory and I/O subsystem, decoder, RAM, timer,
  serial port and board I/O behind one master bus
*/

`timescale 1ns/1ps

module risc5_io (
  input  logic                           clk,
  input  logic                           rst,
  // master bus
  input  logic [soc_map_pkg::ADR_W-1:0]  adr,
  input  logic                           rd,
  input  logic                           wr,
  input  logic                           ben,
  input  logic [soc_map_pkg::DATA_W-1:0] outbus,
  output logic [soc_map_pkg::DATA_W-1:0] inbus,
  output logic                           memwait,
  // serial line
  input  logic                           rxd,
  output logic                           txd,
  // board I/O
  output logic [io_pkg::LED_W-1:0]       led_g,
  input  logic [io_pkg::SW_W-1:0]        sw
);

  logic                           ram_en;
  logic [soc_map_pkg::DATA_W-1:0] ram_dout;

  io_bus_if tmr_bus ();
  io_bus_if bio_bus ();
  io_bus_if ser_bus ();

  // ------------------------------------------------------------
  // decoder and memory
  // ------------------------------------------------------------

  bus_decode u_bus_decode (
    .adr      (adr),
    .rd       (rd),
    .wr       (wr),
    .outbus   (outbus),
    .inbus    (inbus),
    .ram_en   (ram_en),
    .ram_dout (ram_dout),
    .tmr_bus  (tmr_bus),
    .bio_bus  (bio_bus),
    .ser_bus  (ser_bus)
  );

  ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .en      (ram_en),
    .rd      (rd),
    .wr      (wr),
    .ben     (ben),
    .adr     (adr[soc_map_pkg::RAM_AW-1:0]),
    .din     (outbus),
    .dout    (ram_dout),
    .memwait (memwait)
  );

  // ------------------------------------------------------------
  // peripherals
  // ------------------------------------------------------------

  tmr u_tmr (
    .clk (clk),
    .rst (rst),
    .bus (tmr_bus)
  );

  ser u_ser (
    .clk (clk),
    .rst (rst),
    .bus (ser_bus),
    .rxd (rxd),
    .txd (txd)
  );

  bio u_bio (
    .clk   (clk),
    .rst   (rst),
    .bus   (bio_bus),
    .led_g (led_g),
    .sw    (sw)
  );

endmodule

//--- verilog/ser.sv
/*
  ser: 8N1 serial port with one-byte transmit and receive buffers
  and a status register for the ready flags
*/

`timescale 1ns/1ps

module ser (
  input  logic  clk,
  input  logic  rst,
  io_bus_if.dev bus,
  input  logic  rxd,
  output logic  txd
);

  // transmitter
  logic                               tx_busy;
  logic [io_pkg::SER_FRAME_BITS-1:0]  tx_shift;
  logic [io_pkg::SER_CNT_W-1:0]       tx_bit;
  logic [io_pkg::BAUD_CW-1:0]         tx_baud;
  logic                               tx_start;

  // receiver
  logic [1:0]                         rx_sync;
  logic                               rx_busy;
  logic [io_pkg::SER_CNT_W-1:0]       rx_bit;
  logic [io_pkg::BAUD_CW-1:0]         rx_baud;
  logic                               rx_mid;
  logic                               rx_done;
  logic                               rx_rdy;
  logic                               rx_take;
  logic [io_pkg::SER_DATA_BITS-1:0]   rx_shift;
  logic [io_pkg::SER_DATA_BITS-1:0]   rx_data;

  assign tx_start = bus.en & bus.wr & ~bus.sel & ~tx_busy;
  assign rx_take  = bus.en & bus.rd & ~bus.sel;

  // ------------------------------------------------------------
  // transmit
  // ------------------------------------------------------------

  // frame is loaded LSB first, idle line shifts in ones
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_busy  <= 1'b0;
      tx_shift <= '1;
      tx_bit   <= '0;
      tx_baud  <= '0;
    end else if (tx_start) begin
      tx_busy  <= 1'b1;
      tx_shift <= {1'b1, bus.din[io_pkg::SER_DATA_BITS-1:0], 1'b0};
      tx_bit   <= '0;
      tx_baud  <= '0;
    end else if (tx_busy) begin
      if (tx_baud == io_pkg::BAUD_LAST) begin
        tx_baud  <= '0;
        tx_shift <= {1'b1, tx_shift[io_pkg::SER_FRAME_BITS-1:1]};
        if (tx_bit == io_pkg::SER_LAST_BIT) begin
          tx_busy <= 1'b0;
        end else begin
          tx_bit <= tx_bit + 1'b1;
        end
      end else begin
        tx_baud <= tx_baud + 1'b1;
      end
    end
  end

  assign txd = tx_shift[0];

  // ------------------------------------------------------------
  // receive
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_sync <= '1;
    end else begin
      rx_sync <= {rx_sync[0], rxd};
    end
  end

  assign rx_mid  = rx_busy & (rx_baud == io_pkg::BAUD_MID);
  // stop bit sampled high
  assign rx_done = rx_mid & (rx_bit == io_pkg::SER_LAST_BIT) & rx_sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_busy <= 1'b0;
      rx_bit  <= '0;
      rx_baud <= '0;
      rx_rdy  <= 1'b0;
    end else begin
      if (rx_take) begin
        rx_rdy <= 1'b0;
      end
      if (!rx_busy) begin
        // low level on an idle line is a start edge
        if (!rx_sync[1]) begin
          rx_busy <= 1'b1;
          rx_bit  <= '0;
          rx_baud <= '0;
        end
      end else begin
        rx_baud <= (rx_baud == io_pkg::BAUD_LAST) ? '0 : rx_baud + 1'b1;
        if (rx_mid) begin
          rx_bit <= rx_bit + 1'b1;
          if ((rx_bit == '0) && rx_sync[1]) begin
            // start bit gone by mid-period, glitch
            rx_busy <= 1'b0;
          end else if (rx_bit == io_pkg::SER_LAST_BIT) begin
            rx_busy <= 1'b0;
          end
        end
        if (rx_done) begin
          rx_rdy <= 1'b1;
        end
      end
    end
  end

  // data bits enter at the top and push the start bit out
  always_ff @(posedge clk) begin
    if (rx_mid && (rx_bit != io_pkg::SER_LAST_BIT)) begin
      rx_shift <= {rx_sync[1], rx_shift[io_pkg::SER_DATA_BITS-1:1]};
    end
    if (rx_done) begin
      rx_data <= rx_shift;
    end
  end

  // read data: received byte or status word
  always_comb begin
    bus.dout = '0;
    if (bus.sel) begin
      bus.dout[io_pkg::SER_RX_RDY] = rx_rdy;
      bus.dout[io_pkg::SER_TX_RDY] = ~tx_busy;
    end else begin
      bus.dout[io_pkg::SER_DATA_BITS-1:0] = rx_data;
    end
  end

endmodule

//--- verilog/soc_map_pkg.sv
/*
  soc_map_pkg: RISC5 memory map, bus widths, RAM size and I/O register indices
*/

package soc_map_pkg;

  // bus widths
  localparam int ADR_W  = 24;
  localparam int DATA_W = 32;

  // RAM region, selected by the upper address nibble
  localparam logic [3:0] RAM_REGION = 4'h0;
  localparam int RAM_WORDS = 1024;
  // word index plus two byte bits
  localparam int RAM_AW = $clog2(RAM_WORDS) + 2;

  // I/O block occupies the top 64 bytes of the address space
  localparam logic [ADR_W-7:0] IO_PREFIX = '1;

  // register index from adr[5:2]
  localparam logic [3:0] DEV_TMR      = 4'd0;
  localparam logic [3:0] DEV_BIO      = 4'd1;
  localparam logic [3:0] DEV_SER_DATA = 4'd2;
  localparam logic [3:0] DEV_SER_STAT = 4'd3;

endpackage

//--- verilog/tmr.sv
/*
  tmr: free-running millisecond tick counter, read only
*/

`timescale 1ns/1ps

module tmr (
  input  logic  clk,
  input  logic  rst,
  io_bus_if.dev bus
);

  logic [io_pkg::TMR_CW-1:0]      presc;
  logic [soc_map_pkg::DATA_W-1:0] ticks;

  // prescaler wraps every TMR_DIV cycles and bumps the counter
  always_ff @(posedge clk) begin
    if (rst) begin
      presc <= '0;
      ticks <= '0;
    end else if (presc == io_pkg::TMR_LAST) begin
      presc <= '0;
      ticks <= ticks + 1'b1;
    end else begin
      presc <= presc + 1'b1;
    end
  end

  assign bus.dout = ticks;

endmodule
